//--- x86_opnd_decode.f
hdl/x86_opnd_pkg.sv
hdl/addr_fields_if.sv
hdl/modrm_sib_parse.sv
hdl/effective_addr_unit.sv
hdl/opnd_mux_stage.sv
hdl/x86_opnd_decode.sv
tests/x86_opnd_decode_sva.sv
tests/tb_x86_opnd_decode.sv

//--- Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
RUN_FLAGS  := +verilator+error+limit+100
TOP        := tb_x86_opnd_decode
FILELIST   := x86_opnd_decode.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -qx "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_x86_opnd_decode.sv
module tb_x86_opnd_decode;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 16;
  localparam int SEED            = 21929;
  localparam int NUM_DIRECTED    = 19;
  localparam int NUM_RANDOM      = 24;
  localparam int NUM_TESTS       = NUM_DIRECTED + NUM_RANDOM;
  localparam int CYCLES_PER_TEST = 200;
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES + CYCLES_PER_TEST * NUM_TESTS;
  // A result later than this is treated as lost
  localparam int WAIT_LIMIT      = 20;

  logic                       clk;
  logic                       rst_n;
  logic                       instr_valid;
  x86_opnd_pkg::instr_bytes_t instr_bytes;
  x86_opnd_pkg::opnd_form_e   opnd_form;
  logic                       imm_1byte;
  x86_opnd_pkg::cmd_t         opc;
  // Register snapshot in x86 encoding order, EAX first
  x86_opnd_pkg::word_t        gpr [8];
  logic                       hint1_is_write;
  x86_opnd_pkg::word_t        hint1_address;
  x86_opnd_pkg::word_t        hint1_data;
  logic                       hint2_is_write;
  x86_opnd_pkg::word_t        hint2_address;
  x86_opnd_pkg::word_t        hint2_data;
  logic                       opnd_valid;
  x86_opnd_pkg::word_t        opnd0;
  x86_opnd_pkg::word_t        opnd1;
  x86_opnd_pkg::word_t        opnd1_addr;
  x86_opnd_pkg::body_len_t    body_len;

  // Expected results of the instruction in flight
  x86_opnd_pkg::word_t        exp_opnd0;
  x86_opnd_pkg::word_t        exp_opnd1;
  x86_opnd_pkg::word_t        exp_addr;
  x86_opnd_pkg::body_len_t    exp_len;

  int                         tests_run = 0;
  int                         tests_failed = 0;
  logic                       test_failed = 1'b0;

  x86_opnd_decode i_x86_opnd_decode (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid    (instr_valid),
    .instr_bytes    (instr_bytes),
    .opnd_form      (opnd_form),
    .imm_1byte      (imm_1byte),
    .opc            (opc),
    .eax            (gpr[0]),
    .ecx            (gpr[1]),
    .edx            (gpr[2]),
    .ebx            (gpr[3]),
    .esp            (gpr[4]),
    .ebp            (gpr[5]),
    .esi            (gpr[6]),
    .edi            (gpr[7]),
    .hint1_is_write (hint1_is_write),
    .hint1_address  (hint1_address),
    .hint1_data     (hint1_data),
    .hint2_is_write (hint2_is_write),
    .hint2_address  (hint2_address),
    .hint2_data     (hint2_data),
    .opnd_valid     (opnd_valid),
    .opnd0          (opnd0),
    .opnd1          (opnd1),
    .opnd1_addr     (opnd1_addr),
    .body_len       (body_len)
  );

  // Strobe timing and reset checks sit inside the DUT scope
  bind x86_opnd_decode x86_opnd_decode_sva i_x86_opnd_decode_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .opnd_valid  (opnd_valid),
    .opnd0       (opnd0),
    .opnd1       (opnd1),
    .opnd1_addr  (opnd1_addr),
    .body_len    (body_len)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Ends a run that stalls somewhere
  initial begin
    #(CLK_PERIOD * TIMEOUT_CYCLES);
    $display("Watchdog expired before all tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  // Short directed encodings are written as 64-bit literals
  function automatic x86_opnd_pkg::instr_bytes_t zero_ext_bytes(input logic [63:0] v);
    return {24'd0, v};
  endfunction

  // Reference model built from the layout, address and memory rules
  task automatic predict();
    x86_opnd_pkg::byte_t modrm;
    x86_opnd_pkg::byte_t sib;
    x86_opnd_pkg::byte_t one_byte;
    x86_opnd_pkg::word_t disp;
    x86_opnd_pkg::word_t base_val;
    x86_opnd_pkg::word_t index_val;
    x86_opnd_pkg::word_t ea;
    x86_opnd_pkg::word_t mem;
    x86_opnd_pkg::word_t rm_op;
    x86_opnd_pkg::word_t reg_op;
    x86_opnd_pkg::word_t opc_reg;
    x86_opnd_pkg::word_t imm;
    logic uses_rm;
    logic sib_present;
    logic no_base;
    int pos;
    modrm = instr_bytes[15:8];
    sib = instr_bytes[23:16];
    uses_rm = opnd_form inside {x86_opnd_pkg::FORM_RM_REG, x86_opnd_pkg::FORM_REG_RM,
                                x86_opnd_pkg::FORM_RM_IMM};
    sib_present = 1'b0;
    no_base = 1'b0;
    disp = '0;
    base_val = '0;
    index_val = '0;
    imm = '0;
    // Byte position of the next field, the opcode is byte 0
    pos = 1;
    if (uses_rm) begin
      pos = 2;
      sib_present = (modrm[7:6] != 2'd3) && (modrm[2:0] == 3'd4);
      if (sib_present) begin
        pos = 3;
      end
      no_base = (modrm[7:6] == 2'd0) &&
                (sib_present ? (sib[2:0] == 3'd5) : (modrm[2:0] == 3'd5));
      if (modrm[7:6] == 2'd1) begin
        one_byte = x86_opnd_pkg::byte_t'(instr_bytes >> (8 * pos));
        disp = {{24{one_byte[7]}}, one_byte};
        pos += 1;
      end else if (modrm[7:6] == 2'd2 || no_base) begin
        disp = x86_opnd_pkg::word_t'(instr_bytes >> (8 * pos));
        pos += 4;
      end
      if (!no_base) begin
        base_val = gpr[sib_present ? sib[2:0] : modrm[2:0]];
      end
      // ESP code in the index field means no index
      if (sib_present && sib[5:3] != 3'd4) begin
        index_val = gpr[sib[5:3]] << sib[7:6];
      end
    end
    ea = base_val + index_val + disp;
    if (opc == x86_opnd_pkg::CMD_LEA) begin
      mem = ea;
    end else if (!hint1_is_write && hint1_address == ea) begin
      mem = hint1_data;
    end else if (!hint2_is_write && hint2_address == ea) begin
      mem = hint2_data;
    end else begin
      mem = '0;
    end
    if (opnd_form inside {x86_opnd_pkg::FORM_IMM, x86_opnd_pkg::FORM_REG_IMM,
                          x86_opnd_pkg::FORM_RM_IMM}) begin
      one_byte = x86_opnd_pkg::byte_t'(instr_bytes >> (8 * pos));
      if (imm_1byte) begin
        imm = {{24{one_byte[7]}}, one_byte};
        pos += 1;
      end else begin
        imm = x86_opnd_pkg::word_t'(instr_bytes >> (8 * pos));
        pos += 4;
      end
    end
    rm_op = (modrm[7:6] == 2'd3) ? gpr[modrm[2:0]] : mem;
    reg_op = gpr[modrm[5:3]];
    opc_reg = gpr[instr_bytes[2:0]];
    exp_len = x86_opnd_pkg::body_len_t'(pos - 1);
    exp_addr = (uses_rm && modrm[7:6] != 2'd3) ? ea : '0;
    exp_opnd0 = '0;
    exp_opnd1 = '0;
    case (opnd_form)
      x86_opnd_pkg::FORM_REG: exp_opnd0 = opc_reg;
      x86_opnd_pkg::FORM_IMM: exp_opnd0 = imm;
      x86_opnd_pkg::FORM_REG_IMM: begin
        exp_opnd0 = opc_reg;
        exp_opnd1 = imm;
      end
      x86_opnd_pkg::FORM_RM_REG: begin
        exp_opnd0 = rm_op;
        exp_opnd1 = reg_op;
      end
      x86_opnd_pkg::FORM_REG_RM: begin
        exp_opnd0 = reg_op;
        exp_opnd1 = rm_op;
      end
      x86_opnd_pkg::FORM_RM_IMM: begin
        exp_opnd0 = rm_op;
        exp_opnd1 = imm;
      end
      default: ;
    endcase
  endtask

  task automatic compare_field(input string name, input string field,
                               input x86_opnd_pkg::word_t expected,
                               input x86_opnd_pkg::word_t actual);
    assert (actual === expected) else begin
      $display("Fail %s %s expected %08h actual %08h", name, field, expected, actual);
      test_failed = 1'b1;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_failed) begin
      tests_failed++;
    end else begin
      $display("Pass %s", name);
    end
    test_failed = 1'b0;
  endtask

  // Called on a falling edge, returns on the falling edge where the result is checked
  task automatic run_test(input string name, input x86_opnd_pkg::instr_bytes_t bytes,
                          input x86_opnd_pkg::opnd_form_e form, input logic imm1,
                          input x86_opnd_pkg::cmd_t cmd);
    int waited;
    instr_bytes = bytes;
    opnd_form = form;
    imm_1byte = imm1;
    opc = cmd;
    instr_valid = 1'b1;
    predict();
    @(negedge clk);
    instr_valid = 1'b0;
    waited = 0;
    while (!opnd_valid && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!opnd_valid) begin
      $display("Test %s never saw opnd_valid for its instruction", name);
      test_failed = 1'b1;
    end else begin
      compare_field(name, "opnd0", exp_opnd0, opnd0);
      compare_field(name, "opnd1", exp_opnd1, opnd1);
      compare_field(name, "opnd1_addr", exp_addr, opnd1_addr);
      compare_field(name, "body_len", {28'd0, exp_len}, {28'd0, body_len});
    end
    finish_test(name);
  endtask

  task automatic scramble_state();
    for (int i = 0; i < 8; i++) begin
      gpr[i] = $urandom();
    end
    hint1_is_write = 1'($urandom());
    hint1_address = $urandom();
    hint1_data = $urandom();
    hint2_is_write = 1'($urandom());
    hint2_address = $urandom();
    hint2_data = $urandom();
  endtask

  initial begin
    x86_opnd_pkg::instr_bytes_t rand_bytes;
    int pulses;
    void'($urandom(SEED));
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr_bytes = '0;
    opnd_form = x86_opnd_pkg::FORM_NONE;
    imm_1byte = 1'b0;
    opc = '0;
    for (int i = 0; i < 8; i++) begin
      gpr[i] = 32'h1111_1111 * (i + 1);
    end
    hint1_is_write = 1'b1;
    hint1_address = '0;
    hint1_data = '0;
    hint2_is_write = 1'b1;
    hint2_address = '0;
    hint2_data = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    compare_field("reset_state", "opnd_valid", 32'd0, {31'd0, opnd_valid});
    compare_field("reset_state", "opnd0", 32'd0, opnd0);
    compare_field("reset_state", "opnd1", 32'd0, opnd1);
    compare_field("reset_state", "opnd1_addr", 32'd0, opnd1_addr);
    compare_field("reset_state", "body_len", 32'd0, {28'd0, body_len});
    finish_test("reset_state");

    // Register and immediate forms, opcode low bits pick the short-form register
    run_test("reg_opcode", zero_ext_bytes(64'h53), x86_opnd_pkg::FORM_REG, 1'b0, 7'h01);
    run_test("rm_reg_direct", zero_ext_bytes(64'hC801), x86_opnd_pkg::FORM_RM_REG, 1'b0, 7'h01);
    run_test("reg_rm_direct", zero_ext_bytes(64'hDE8B), x86_opnd_pkg::FORM_REG_RM, 1'b0, 7'h02);
    run_test("imm8_neg", zero_ext_bytes(64'hF06A), x86_opnd_pkg::FORM_IMM, 1'b1, 7'h03);
    run_test("imm32", zero_ext_bytes(64'h1234_5678_68), x86_opnd_pkg::FORM_IMM, 1'b0, 7'h03);
    run_test("reg_imm32", zero_ext_bytes(64'hCAFE_BABE_B9), x86_opnd_pkg::FORM_REG_IMM, 1'b0,
             7'h04);
    run_test("rm_imm8_reg", zero_ext_bytes(64'h80C283), x86_opnd_pkg::FORM_RM_IMM, 1'b1, 7'h05);
    run_test("rm_imm32_mem", zero_ext_bytes(64'h0000_0010_FC45_81), x86_opnd_pkg::FORM_RM_IMM,
             1'b0, 7'h05);

    // Addressing corners: bare disp32, SIB without base, index 4, ESP base
    run_test("addr_no_base", zero_ext_bytes(64'h4433_2211_058B), x86_opnd_pkg::FORM_REG_RM,
             1'b0, 7'h02);
    run_test("addr_sib_no_base", zero_ext_bytes(64'h0000_1000_8D04_8B),
             x86_opnd_pkg::FORM_REG_RM, 1'b0, 7'h02);
    run_test("addr_sib_index4", zero_ext_bytes(64'h8000_0000_E384_8B),
             x86_opnd_pkg::FORM_REG_RM, 1'b0, 7'h02);
    run_test("addr_disp8_sib", zero_ext_bytes(64'h8074_448B), x86_opnd_pkg::FORM_RM_REG,
             1'b0, 7'h01);

    // Memory operand at [EBX] against the two read hints
    hint1_is_write = 1'b0;
    hint1_address = gpr[3];
    hint1_data = 32'hAAAA_5555;
    hint2_is_write = 1'b0;
    hint2_address = gpr[3];
    hint2_data = 32'h5555_AAAA;
    run_test("hint1_read", zero_ext_bytes(64'h038B), x86_opnd_pkg::FORM_REG_RM, 1'b0, 7'h02);
    hint1_is_write = 1'b1;
    run_test("hint2_read", zero_ext_bytes(64'h038B), x86_opnd_pkg::FORM_REG_RM, 1'b0, 7'h02);
    hint2_is_write = 1'b1;
    run_test("hint_write_only", zero_ext_bytes(64'h038B), x86_opnd_pkg::FORM_REG_RM, 1'b0,
             7'h02);
    hint1_is_write = 1'b0;
    hint2_is_write = 1'b0;
    hint1_address = gpr[3] + 32'd4;
    hint2_address = gpr[3] + 32'd8;
    run_test("hint_miss", zero_ext_bytes(64'h038B), x86_opnd_pkg::FORM_REG_RM, 1'b0, 7'h02);
    hint1_address = gpr[3];
    run_test("lea_ignores_hints", zero_ext_bytes(64'h038D), x86_opnd_pkg::FORM_REG_RM, 1'b0,
             x86_opnd_pkg::CMD_LEA);

    // Three strobes in a row must come back as three result cycles
    pulses = 0;
    instr_bytes = zero_ext_bytes(64'h50);
    opnd_form = x86_opnd_pkg::FORM_REG;
    instr_valid = 1'b1;
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      if (i == 2) begin
        instr_valid = 1'b0;
      end
      if (opnd_valid) begin
        pulses++;
      end
    end
    compare_field("back_to_back", "pulses", 32'd3, 32'(pulses));
    finish_test("back_to_back");

    // Random memory-mode encodings with fresh registers and hints each time
    for (int t = 0; t < NUM_RANDOM; t++) begin
      scramble_state();
      rand_bytes = x86_opnd_pkg::instr_bytes_t'({$urandom(), $urandom(), $urandom()});
      rand_bytes[15:14] = 2'($urandom_range(2, 0));
      run_test($sformatf("rand_addr_%0d", t), rand_bytes,
               t[0] ? x86_opnd_pkg::FORM_REG_RM : x86_opnd_pkg::FORM_RM_REG, 1'b0,
               x86_opnd_pkg::cmd_t'($urandom()));
    end

    $display("%0d tests run, %0d failed, %0d assertion failures", tests_run, tests_failed,
             i_x86_opnd_decode.i_x86_opnd_decode_sva.assert_failures);
    if (tests_failed == 0 && i_x86_opnd_decode.i_x86_opnd_decode_sva.assert_failures == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- tests/x86_opnd_decode_sva.sv
module x86_opnd_decode_sva (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    instr_valid,
  input logic                    opnd_valid,
  input x86_opnd_pkg::word_t     opnd0,
  input x86_opnd_pkg::word_t     opnd1,
  input x86_opnd_pkg::word_t     opnd1_addr,
  input x86_opnd_pkg::body_len_t body_len
);

  // Number of assertion failures seen so far
  int unsigned assert_failures = 0;

  // High once the first result after reset has been presented
  logic result_seen;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_seen <= 1'b0;
    end else if (opnd_valid) begin
      result_seen <= 1'b1;
    end
  end

  // Every strobe gives exactly one result one cycle later, and nothing else does
  valid_follows_strobe: assert property (
    @(posedge clk) rst_n |=> (opnd_valid == $past(instr_valid))
  ) else begin
    $error("opnd_valid did not follow instr_valid by exactly one cycle");
    assert_failures++;
  end

  // The strobe register clears on the first edge in reset
  valid_low_in_reset: assert property (
    @(posedge clk) !rst_n |=> !opnd_valid
  ) else begin
    $error("opnd_valid was high after a reset cycle");
    assert_failures++;
  end

  // Until the first result the data outputs keep their reset value
  outputs_zero_before_result: assert property (
    @(posedge clk) disable iff (!rst_n)
    (!result_seen && !opnd_valid) |->
      (opnd0 == '0 && opnd1 == '0 && opnd1_addr == '0 && body_len == '0)
  ) else begin
    $error("data outputs were not zero before the first result");
    assert_failures++;
  end

endmodule

//--- hdl/x86_opnd_decode.sv
module x86_opnd_decode (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        instr_valid,
  input  x86_opnd_pkg::instr_bytes_t  instr_bytes,
  input  x86_opnd_pkg::opnd_form_e    opnd_form,
  input  logic                        imm_1byte,
  input  x86_opnd_pkg::cmd_t          opc,
  input  x86_opnd_pkg::word_t         eax,
  input  x86_opnd_pkg::word_t         ecx,
  input  x86_opnd_pkg::word_t         edx,
  input  x86_opnd_pkg::word_t         ebx,
  input  x86_opnd_pkg::word_t         esp,
  input  x86_opnd_pkg::word_t         ebp,
  input  x86_opnd_pkg::word_t         esi,
  input  x86_opnd_pkg::word_t         edi,
  input  logic                        hint1_is_write,
  input  x86_opnd_pkg::word_t         hint1_address,
  input  x86_opnd_pkg::word_t         hint1_data,
  input  logic                        hint2_is_write,
  input  x86_opnd_pkg::word_t         hint2_address,
  input  x86_opnd_pkg::word_t         hint2_data,
  output logic                        opnd_valid,
  output x86_opnd_pkg::word_t         opnd0,
  output x86_opnd_pkg::word_t         opnd1,
  output x86_opnd_pkg::word_t         opnd1_addr,
  output x86_opnd_pkg::body_len_t     body_len
);

  x86_opnd_pkg::gpr_file_t gprs;
  x86_opnd_pkg::regsel_t   opcode_regsel;
  x86_opnd_pkg::word_t     mem_addr;
  x86_opnd_pkg::word_t     mem_value;
  x86_opnd_pkg::body_len_t body_len_comb;

  addr_fields_if fields ();

  // Packed so that the register selector indexes it directly, EAX at 0
  assign gprs = {edi, esi, ebp, esp, ebx, edx, ecx, eax};

  // Short forms like PUSH r32 encode the register in the opcode's low bits
  assign opcode_regsel = instr_bytes[2:0];

  modrm_sib_parse i_modrm_sib_parse (
    .instr_bytes (instr_bytes),
    .opnd_form   (opnd_form),
    .imm_1byte   (imm_1byte),
    .fields      (fields.parser),
    .body_len    (body_len_comb)
  );

  effective_addr_unit i_effective_addr_unit (
    .gprs           (gprs),
    .fields         (fields.consumer),
    .opc            (opc),
    .hint1_is_write (hint1_is_write),
    .hint1_address  (hint1_address),
    .hint1_data     (hint1_data),
    .hint2_is_write (hint2_is_write),
    .hint2_address  (hint2_address),
    .hint2_data     (hint2_data),
    .mem_addr       (mem_addr),
    .mem_value      (mem_value)
  );

  // Single register stage, one instruction in flight per cycle
  opnd_mux_stage #(
    .RESET_OUTPUTS (1'b1)
  ) i_opnd_mux_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid   (instr_valid),
    .opnd_form     (opnd_form),
    .opcode_regsel (opcode_regsel),
    .gprs          (gprs),
    .fields        (fields.consumer),
    .mem_addr      (mem_addr),
    .mem_value     (mem_value),
    .body_len_in   (body_len_comb),
    .opnd_valid    (opnd_valid),
    .opnd0         (opnd0),
    .opnd1         (opnd1),
    .opnd1_addr    (opnd1_addr),
    .body_len      (body_len)
  );

endmodule

//--- hdl/opnd_mux_stage.sv
module opnd_mux_stage #(
  // Set to 0 to leave the data registers without reset
  parameter bit RESET_OUTPUTS = 1'b1
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        instr_valid,
  input  x86_opnd_pkg::opnd_form_e    opnd_form,
  input  x86_opnd_pkg::regsel_t       opcode_regsel,
  input  x86_opnd_pkg::gpr_file_t     gprs,
  addr_fields_if.consumer             fields,
  input  x86_opnd_pkg::word_t         mem_addr,
  input  x86_opnd_pkg::word_t         mem_value,
  input  x86_opnd_pkg::body_len_t     body_len_in,
  output logic                        opnd_valid,
  output x86_opnd_pkg::word_t         opnd0,
  output x86_opnd_pkg::word_t         opnd1,
  output x86_opnd_pkg::word_t         opnd1_addr,
  output x86_opnd_pkg::body_len_t     body_len
);

  logic                rm_is_mem;
  logic                mem_used;
  x86_opnd_pkg::word_t rm_val;
  x86_opnd_pkg::word_t reg_val;
  x86_opnd_pkg::word_t opc_reg_val;
  x86_opnd_pkg::word_t opnd0_next;
  x86_opnd_pkg::word_t opnd1_next;
  x86_opnd_pkg::word_t addr_next;

  // Mod 3 is register direct, every other mod addresses memory
  assign rm_is_mem = fields.mod != 2'd3;

  assign rm_val      = rm_is_mem ? mem_value : gprs[fields.rm];
  assign reg_val     = gprs[fields.reg_sel];
  assign opc_reg_val = gprs[opcode_regsel];

  // Operands that the form leaves unused are forced to zero
  always_comb begin
    opnd0_next = '0;
    opnd1_next = '0;
    case (opnd_form)
      x86_opnd_pkg::FORM_REG: begin
        opnd0_next = opc_reg_val;
      end
      x86_opnd_pkg::FORM_IMM: begin
        opnd0_next = fields.imm;
      end
      x86_opnd_pkg::FORM_REG_IMM: begin
        opnd0_next = opc_reg_val;
        opnd1_next = fields.imm;
      end
      x86_opnd_pkg::FORM_RM_REG: begin
        opnd0_next = rm_val;
        opnd1_next = reg_val;
      end
      x86_opnd_pkg::FORM_REG_RM: begin
        opnd0_next = reg_val;
        opnd1_next = rm_val;
      end
      x86_opnd_pkg::FORM_RM_IMM: begin
        opnd0_next = rm_val;
        opnd1_next = fields.imm;
      end
      default: begin
        opnd0_next = '0;
        opnd1_next = '0;
      end
    endcase
  end

  // The address is only reported when some operand really is in memory
  assign mem_used  = x86_opnd_pkg::HAS_MODRM(opnd_form) && rm_is_mem;
  assign addr_next = mem_used ? mem_addr : '0;

  // The strobe always has a reset so no phantom result follows reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      opnd_valid <= 1'b0;
    end else begin
      opnd_valid <= instr_valid;
    end
  end

  // Results are captured once per strobe and hold until the next one
  always_ff @(posedge clk) begin
    if (RESET_OUTPUTS && !rst_n) begin
      opnd0      <= '0;
      opnd1      <= '0;
      opnd1_addr <= '0;
      body_len   <= '0;
    end else if (instr_valid) begin
      opnd0      <= opnd0_next;
      opnd1      <= opnd1_next;
      opnd1_addr <= addr_next;
      body_len   <= body_len_in;
    end
  end

endmodule

//--- hdl/effective_addr_unit.sv
module effective_addr_unit (
  input  x86_opnd_pkg::gpr_file_t gprs,
  addr_fields_if.consumer         fields,
  input  x86_opnd_pkg::cmd_t      opc,
  input  logic                    hint1_is_write,
  input  x86_opnd_pkg::word_t     hint1_address,
  input  x86_opnd_pkg::word_t     hint1_data,
  input  logic                    hint2_is_write,
  input  x86_opnd_pkg::word_t     hint2_address,
  input  x86_opnd_pkg::word_t     hint2_data,
  output x86_opnd_pkg::word_t     mem_addr,
  output x86_opnd_pkg::word_t     mem_value
);

  x86_opnd_pkg::regsel_t base_sel;
  logic                  no_base;
  logic                  no_index;
  x86_opnd_pkg::word_t   base_val;
  x86_opnd_pkg::word_t   index_val;
  logic                  hint1_hit;
  logic                  hint2_hit;

  // Without SIB the base register is named directly by ModR/M.rm
  assign base_sel = fields.has_sib ? fields.base : fields.rm;

  // Mod 0 with a base code of 5 means disp32 only, so the base drops out
  assign no_base = (fields.mod == 2'd0) && (base_sel == x86_opnd_pkg::NO_BASE_SEL);

  // ESP can never serve as an index, its code means no index at all
  assign no_index = !fields.has_sib || (fields.index == x86_opnd_pkg::REG_ESP_SEL);

  assign base_val = no_base ? '0 : gprs[base_sel];

  // Scale multiplies the index by 1, 2, 4 or 8
  assign index_val = no_index ? '0 : (gprs[fields.index] << fields.scale);

  // Wraps modulo 2^32 like the real AGU
  assign mem_addr = base_val + index_val + fields.disp;

  // A read hint at the same address supplies the memory data
  assign hint1_hit = !hint1_is_write && (hint1_address == mem_addr);
  assign hint2_hit = !hint2_is_write && (hint2_address == mem_addr);

  // LEA returns the address itself, otherwise hint1 has priority over hint2
  always_comb begin
    if (opc == x86_opnd_pkg::CMD_LEA) begin
      mem_value = mem_addr;
    end else if (hint1_hit) begin
      mem_value = hint1_data;
    end else if (hint2_hit) begin
      mem_value = hint2_data;
    end else begin
      // No usable hint, memory is not modeled here
      mem_value = '0;
    end
  end

endmodule

//--- hdl/modrm_sib_parse.sv
module modrm_sib_parse (
  input  x86_opnd_pkg::instr_bytes_t instr_bytes,
  input  x86_opnd_pkg::opnd_form_e    opnd_form,
  input  logic                        imm_1byte,
  addr_fields_if.parser               fields,
  output x86_opnd_pkg::body_len_t     body_len
);

  logic                    has_modrm;
  logic                    has_imm;
  x86_opnd_pkg::byte_t     modrm;
  x86_opnd_pkg::byte_t     sib;
  logic                    no_base_disp32;
  x86_opnd_pkg::body_len_t disp_len;
  x86_opnd_pkg::body_len_t imm_len;
  x86_opnd_pkg::body_len_t disp_off;
  x86_opnd_pkg::body_len_t imm_off;
  x86_opnd_pkg::instr_bytes_t disp_window;
  x86_opnd_pkg::instr_bytes_t imm_window;

  assign has_modrm = x86_opnd_pkg::HAS_MODRM(opnd_form);
  assign has_imm   = opnd_form inside {x86_opnd_pkg::FORM_IMM, x86_opnd_pkg::FORM_REG_IMM,
                                       x86_opnd_pkg::FORM_RM_IMM};

  // ModR/M sits right after the opcode, SIB right after ModR/M
  assign modrm = instr_bytes[15:8];
  assign sib   = instr_bytes[23:16];

  assign fields.mod     = modrm[7:6];
  assign fields.reg_sel = modrm[5:3];
  assign fields.rm      = modrm[2:0];

  // A SIB byte exists only in the memory modes when rm selects it
  assign fields.has_sib = has_modrm && (modrm[7:6] != 2'd3) &&
                          (modrm[2:0] == x86_opnd_pkg::RM_SIB_SEL);

  assign fields.scale = sib[7:6];
  assign fields.index = sib[5:3];
  assign fields.base  = sib[2:0];

  // Mod 0 with rm 5, or with SIB base 5, switches to a bare disp32
  assign no_base_disp32 = (modrm[7:6] == 2'd0) &&
                          (fields.has_sib ? (sib[2:0] == x86_opnd_pkg::NO_BASE_SEL)
                                          : (modrm[2:0] == x86_opnd_pkg::NO_BASE_SEL));

  always_comb begin
    disp_len = 4'd0;
    if (has_modrm) begin
      if (modrm[7:6] == 2'd1) begin
        disp_len = 4'd1;
      end else if (modrm[7:6] == 2'd2 || no_base_disp32) begin
        disp_len = 4'd4;
      end
    end
  end

  assign imm_len = !has_imm  ? 4'd0 :
                   imm_1byte ? 4'd1 : 4'd4;

  // Byte offsets of the trailing fields, counted from the opcode byte
  assign disp_off = 4'd1 + {3'b000, has_modrm} + {3'b000, fields.has_sib};
  assign imm_off  = disp_off + disp_len;

  // Shift the wanted field down to bit 0 so extraction is a fixed slice
  assign disp_window = instr_bytes >> {disp_off, 3'b000};
  assign imm_window  = instr_bytes >> {imm_off, 3'b000};

  always_comb begin
    fields.disp = '0;
    if (disp_len == 4'd1) begin
      fields.disp = {{24{disp_window[7]}}, disp_window[7:0]};
    end else if (disp_len == 4'd4) begin
      fields.disp = disp_window[31:0];
    end
  end

  // The 1-byte immediate is sign-extended to the full operand width
  always_comb begin
    fields.imm = '0;
    if (has_imm) begin
      fields.imm = imm_1byte ? {{24{imm_window[7]}}, imm_window[7:0]} : imm_window[31:0];
    end
  end

  // The opcode byte itself is not part of the body
  assign body_len = {3'b000, has_modrm} + {3'b000, fields.has_sib} + disp_len + imm_len;

endmodule

//--- hdl/addr_fields_if.sv
// Parsed addressing fields of one instruction, purely combinational
interface addr_fields_if;
  logic [1:0]              mod;
  // Named reg_sel since reg is a reserved word
  x86_opnd_pkg::regsel_t   reg_sel;
  x86_opnd_pkg::regsel_t   rm;
  logic                    has_sib;
  x86_opnd_pkg::scale_t    scale;
  x86_opnd_pkg::regsel_t   index;
  x86_opnd_pkg::regsel_t   base;
  // Sign-extended displacement, zero when the encoding has none
  x86_opnd_pkg::word_t     disp;
  // Sign-extended immediate, zero when the form has none
  x86_opnd_pkg::word_t     imm;

  modport parser (
    output mod, reg_sel, rm, has_sib, scale, index, base, disp, imm
  );

  modport consumer (
    input mod, reg_sel, rm, has_sib, scale, index, base, disp, imm
  );
endinterface

//--- hdl/x86_opnd_pkg.sv
package x86_opnd_pkg;

  // Architectural register width for 32-bit protected mode
  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;
  // Index 0 is EAX, following the x86 register encoding order
  typedef word_t [7:0] gpr_file_t;
  typedef logic [2:0] regsel_t;
  typedef logic [1:0] scale_t;
  typedef logic [7:0] byte_t;
  // Eleven bytes with the opcode in bits 7:0
  typedef logic [87:0] instr_bytes_t;
  typedef logic [3:0] body_len_t;
  typedef logic [6:0] cmd_t;

  // Command code of LEA, which uses the AGU but never touches memory
  localparam cmd_t CMD_LEA = 7'h2d;

  // Operand forms, named by where operand 0 and operand 1 come from
  typedef enum logic [2:0] {
    FORM_NONE    = 3'd0,
    FORM_REG     = 3'd1,
    FORM_IMM     = 3'd2,
    FORM_REG_IMM = 3'd3,
    FORM_RM_REG  = 3'd4,
    FORM_REG_RM  = 3'd5,
    FORM_RM_IMM  = 3'd6
  } opnd_form_e;

  // ESP as an SIB index means there is no index
  localparam regsel_t REG_ESP_SEL = 3'd4;
  // ModR/M.rm value that announces a SIB byte
  localparam regsel_t RM_SIB_SEL = 3'd4;
  // With mod 0 this rm or SIB base value means disp32 and no base
  localparam regsel_t NO_BASE_SEL = 3'd5;

  // True for every form that carries a ModR/M byte
  function automatic logic HAS_MODRM(input opnd_form_e form);
    return form inside {FORM_RM_REG, FORM_REG_RM, FORM_RM_IMM};
  endfunction

endpackage
